/* hdl/rcc_reg_pkg.sv */
`default_nettype none

// register map of the software reset block
package rcc_reg_pkg;

    // data port and reset vector width
    localparam int reg_width = 32;

    // byte offset on the register port
    typedef logic [3:0] reg_addr_t;

    // d1 peripherals, memories and graphics
    localparam reg_addr_t addr_d1_rstr = 4'h0;

    // d2 peripherals, communication and timers
    localparam reg_addr_t addr_d2_rstr = 4'h4;

    // d3 peripherals, always-on domain
    localparam reg_addr_t addr_d3_rstr = 4'h8;

endpackage

`default_nettype wire

/* hdl/rcc_domain_pkg.sv */
`default_nettype none

// power domains that can be put in standby
package rcc_domain_pkg;

    // bit positions in the standby and domain reset vectors
    typedef enum int unsigned {
        dom_d1 = 0,
        dom_d2 = 1
    } dom_idx_e;

    // d3 is always on and has no sequencer
    localparam int num_sw_domains = 2;

    // hold in cycles after standby drops
    localparam int default_release_delay = 4;

endpackage

`default_nettype wire

/* hdl/rcc_rst_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_regs #(
    parameter logic [rcc_reg_pkg::reg_width-1:0] D1_SW_MASK = '1,
    parameter logic [rcc_reg_pkg::reg_width-1:0] D2_SW_MASK = '1,
    parameter logic [rcc_reg_pkg::reg_width-1:0] D3_SW_MASK = '1
) (
    input  wire                                 hclk,
    input  wire                                 rst_n,

    // write port, one-cycle strobe
    input  wire                                 wr_en,
    input  wire rcc_reg_pkg::reg_addr_t         wr_addr,
    input  wire [rcc_reg_pkg::reg_width-1:0]    wr_data,

    // read port, combinational
    input  wire rcc_reg_pkg::reg_addr_t         rd_addr,
    output logic [rcc_reg_pkg::reg_width-1:0]   rd_data,

    // software reset bits, active high
    output logic [rcc_reg_pkg::reg_width-1:0]   d1_rstr,
    output logic [rcc_reg_pkg::reg_width-1:0]   d2_rstr,
    output logic [rcc_reg_pkg::reg_width-1:0]   d3_rstr
);

    logic [rcc_reg_pkg::reg_width-1:0] d1_q;
    logic [rcc_reg_pkg::reg_width-1:0] d2_q;
    logic [rcc_reg_pkg::reg_width-1:0] d3_q;

    // masked write, unknown offsets are dropped
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            d1_q <= '0;
            d2_q <= '0;
            d3_q <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                rcc_reg_pkg::addr_d1_rstr: d1_q <= wr_data & D1_SW_MASK;
                rcc_reg_pkg::addr_d2_rstr: d2_q <= wr_data & D2_SW_MASK;
                rcc_reg_pkg::addr_d3_rstr: d3_q <= wr_data & D3_SW_MASK;
                default: begin
                end
            endcase
        end
    end

    // readback, zero for holes in the map
    always_comb begin
        case (rd_addr)
            rcc_reg_pkg::addr_d1_rstr: rd_data = d1_q;
            rcc_reg_pkg::addr_d2_rstr: rd_data = d2_q;
            rcc_reg_pkg::addr_d3_rstr: rd_data = d3_q;
            default:                   rd_data = '0;
        endcase
    end

    assign d1_rstr = d1_q;
    assign d2_rstr = d2_q;
    assign d3_rstr = d3_q;

    // unmasked bits must never hold a one, else a peripheral
    // without a software reset could be held in reset
    a_rstr_within_mask: assert property (
        @(posedge hclk) disable iff (!rst_n)
        ((d1_q & ~D1_SW_MASK) == '0) &&
        ((d2_q & ~D2_SW_MASK) == '0) &&
        ((d3_q & ~D3_SW_MASK) == '0)
    ) else $error("software reset bit set outside its mask");

endmodule

`default_nettype wire

/* hdl/rcc_domain_rst_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_domain_rst_seq #(
    parameter int RELEASE_DELAY = 4
) (
    input  wire                                         hclk,
    input  wire                                         rst_n,

    // standby request per switchable domain, level
    input  wire [rcc_domain_pkg::num_sw_domains-1:0]    standby,

    // domain reset, active low
    output logic [rcc_domain_pkg::num_sw_domains-1:0]   dom_rst_n
);

    // counter wide enough for the hold, at least one bit
    localparam int cnt_w = (RELEASE_DELAY > 0) ? $clog2(RELEASE_DELAY + 1) : 1;
    localparam logic [cnt_w-1:0] cnt_load = cnt_w'(RELEASE_DELAY);

    for (genvar i = 0; i < rcc_domain_pkg::num_sw_domains; i++) begin : g_dom

        logic [1:0]       sync_q;
        logic [cnt_w-1:0] cnt_q;
        logic             rst_q;

        always_ff @(posedge hclk or negedge rst_n) begin
            if (!rst_n) begin
                sync_q <= 2'b00;
                cnt_q  <= cnt_load;
                rst_q  <= 1'b0;
            end else begin
                // release of the system reset, two flops
                sync_q <= {sync_q[0], 1'b1};

                if (standby[i]) begin
                    // assert at once and rearm the hold
                    cnt_q <= cnt_load;
                    rst_q <= 1'b0;
                end else if (sync_q[1]) begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                    // last count step opens the domain
                    rst_q <= (cnt_q <= cnt_w'(1));
                end
            end
        end

        assign dom_rst_n[i] = rst_q;

        // a request seen at an edge must hold the domain in reset after it
        a_standby_holds_rst: assert property (
            @(posedge hclk) disable iff (!rst_n)
            standby[i] |=> !dom_rst_n[i]
        ) else $error("domain %0d left reset during standby", i);

    end

endmodule

`default_nettype wire

/* hdl/rcc_per_rst_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_per_rst_combine #(
    parameter logic [rcc_reg_pkg::reg_width-1:0] D1_SW_MASK = '1,
    parameter logic [rcc_reg_pkg::reg_width-1:0] D2_SW_MASK = '1,
    parameter logic [rcc_reg_pkg::reg_width-1:0] D3_SW_MASK = '1
) (
    // system reset, active low
    input  wire                                         rst_n,

    // domain resets from the sequencer
    input  wire [rcc_domain_pkg::num_sw_domains-1:0]    dom_rst_n,

    // software reset bits, active high
    input  wire [rcc_reg_pkg::reg_width-1:0]            d1_rstr,
    input  wire [rcc_reg_pkg::reg_width-1:0]            d2_rstr,
    input  wire [rcc_reg_pkg::reg_width-1:0]            d3_rstr,

    // one reset per peripheral, active low
    output logic [rcc_reg_pkg::reg_width-1:0]           d1_per_rst_n,
    output logic [rcc_reg_pkg::reg_width-1:0]           d2_per_rst_n,
    output logic [rcc_reg_pkg::reg_width-1:0]           d3_per_rst_n
);

    logic d1_en;
    logic d2_en;

    // system and domain reset for the switchable domains
    assign d1_en = rst_n & dom_rst_n[rcc_domain_pkg::dom_d1];
    assign d2_en = rst_n & dom_rst_n[rcc_domain_pkg::dom_d2];

    // software bit only counts where the peripheral has one
    assign d1_per_rst_n = {rcc_reg_pkg::reg_width{d1_en}} & ~(d1_rstr & D1_SW_MASK);
    assign d2_per_rst_n = {rcc_reg_pkg::reg_width{d2_en}} & ~(d2_rstr & D2_SW_MASK);

    // d3 is always on, no domain term
    assign d3_per_rst_n = {rcc_reg_pkg::reg_width{rst_n}} & ~(d3_rstr & D3_SW_MASK);

    // system reset reaches every peripheral with no delay
    always_comb begin
        if (!rst_n) begin
            a_sys_rst_all_low: assert final (
                (d1_per_rst_n == '0) && (d2_per_rst_n == '0) && (d3_per_rst_n == '0)
            ) else $error("peripheral out of reset during system reset");
        end
    end

endmodule

`default_nettype wire

/* hdl/rcc_rst_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_top #(
    parameter logic [rcc_reg_pkg::reg_width-1:0] D1_SW_MASK    = 32'h0000_00FF,
    parameter logic [rcc_reg_pkg::reg_width-1:0] D2_SW_MASK    = 32'h0000_FFFF,
    parameter logic [rcc_reg_pkg::reg_width-1:0] D3_SW_MASK    = 32'h00FF_FFF0,
    parameter int                                RELEASE_DELAY =
        rcc_domain_pkg::default_release_delay
) (
    input  wire                                 hclk,
    input  wire                                 rst_n,

    // register port
    input  wire                                 wr_en,
    input  wire rcc_reg_pkg::reg_addr_t         wr_addr,
    input  wire [rcc_reg_pkg::reg_width-1:0]    wr_data,
    input  wire rcc_reg_pkg::reg_addr_t         rd_addr,
    output logic [rcc_reg_pkg::reg_width-1:0]   rd_data,

    // standby requests, level
    input  wire                                 d1_standby,
    input  wire                                 d2_standby,

    output logic [rcc_reg_pkg::reg_width-1:0]   d1_per_rst_n,
    output logic [rcc_reg_pkg::reg_width-1:0]   d2_per_rst_n,
    output logic [rcc_reg_pkg::reg_width-1:0]   d3_per_rst_n,

    // domain reset status
    output logic                                d1_rst_n,
    output logic                                d2_rst_n
);

    logic [rcc_reg_pkg::reg_width-1:0]          d1_rstr;
    logic [rcc_reg_pkg::reg_width-1:0]          d2_rstr;
    logic [rcc_reg_pkg::reg_width-1:0]          d3_rstr;
    logic [rcc_domain_pkg::num_sw_domains-1:0]  standby;
    logic [rcc_domain_pkg::num_sw_domains-1:0]  dom_rst_n;

    assign standby[rcc_domain_pkg::dom_d1] = d1_standby;
    assign standby[rcc_domain_pkg::dom_d2] = d2_standby;

    assign d1_rst_n = dom_rst_n[rcc_domain_pkg::dom_d1];
    assign d2_rst_n = dom_rst_n[rcc_domain_pkg::dom_d2];

    rcc_rst_regs #(
        .D1_SW_MASK (D1_SW_MASK),
        .D2_SW_MASK (D2_SW_MASK),
        .D3_SW_MASK (D3_SW_MASK)
    ) u_regs (
        .hclk    (hclk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .d1_rstr (d1_rstr),
        .d2_rstr (d2_rstr),
        .d3_rstr (d3_rstr)
    );

    rcc_domain_rst_seq #(
        .RELEASE_DELAY (RELEASE_DELAY)
    ) u_seq (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .standby   (standby),
        .dom_rst_n (dom_rst_n)
    );

    rcc_per_rst_combine #(
        .D1_SW_MASK (D1_SW_MASK),
        .D2_SW_MASK (D2_SW_MASK),
        .D3_SW_MASK (D3_SW_MASK)
    ) u_combine (
        .rst_n        (rst_n),
        .dom_rst_n    (dom_rst_n),
        .d1_rstr      (d1_rstr),
        .d2_rstr      (d2_rstr),
        .d3_rstr      (d3_rstr),
        .d1_per_rst_n (d1_per_rst_n),
        .d2_per_rst_n (d2_per_rst_n),
        .d3_per_rst_n (d3_per_rst_n)
    );

endmodule

`default_nettype wire

/* tb/rcc_rst_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_tb;

    localparam int dw = rcc_reg_pkg::reg_width;
    localparam int nd = rcc_domain_pkg::num_sw_domains;
    localparam int release_delay = rcc_domain_pkg::default_release_delay;
    localparam logic [dw-1:0] d1_mask = 32'h0000_00FF;
    localparam logic [dw-1:0] d2_mask = 32'h0000_FFFF;
    localparam logic [dw-1:0] d3_mask = 32'h00FF_FFF0;
    localparam int clk_period = 10;
    localparam int num_rand = 40;

    // cycles per test: reset, random, walking bit, standby, restart, system reset
    localparam int test_cycles = (40 + release_delay) + num_rand * 4 + 3 * 34 * 2
        + 2 * (30 + release_delay) + 2 * (30 + release_delay) + (50 + release_delay);
    localparam int timeout_ns = (test_cycles + 200) * clk_period;

    logic                   hclk;
    logic                   rst_n;
    logic                   wr_en;
    rcc_reg_pkg::reg_addr_t wr_addr;
    logic [dw-1:0]          wr_data;
    rcc_reg_pkg::reg_addr_t rd_addr;
    logic [dw-1:0]          rd_data;
    logic                   d1_standby;
    logic                   d2_standby;
    logic [dw-1:0]          d1_per_rst_n;
    logic [dw-1:0]          d2_per_rst_n;
    logic [dw-1:0]          d3_per_rst_n;
    logic                   d1_rst_n;
    logic                   d2_rst_n;

    // reference state, shadow registers and expected domain resets
    logic [dw-1:0] sh_d1;
    logic [dw-1:0] sh_d2;
    logic [dw-1:0] sh_d3;
    logic [nd-1:0] exp_dom;
    logic [nd-1:0] standby_vec;
    int            hold [nd];

    integer seed = 46;
    int     err_count = 0;
    int     check_count = 0;
    int     step_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_err_start = 0;
    string  test_name;
    logic   check_en = 1'b0;

    rcc_rst_top #(
        .D1_SW_MASK    (d1_mask),
        .D2_SW_MASK    (d2_mask),
        .D3_SW_MASK    (d3_mask),
        .RELEASE_DELAY (release_delay)
    ) dut (
        .hclk         (hclk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .d1_standby   (d1_standby),
        .d2_standby   (d2_standby),
        .d1_per_rst_n (d1_per_rst_n),
        .d2_per_rst_n (d2_per_rst_n),
        .d3_per_rst_n (d3_per_rst_n),
        .d1_rst_n     (d1_rst_n),
        .d2_rst_n     (d2_rst_n)
    );

    initial begin
        hclk = 1'b0;
        forever #(clk_period / 2) hclk = ~hclk;
    end

    assign standby_vec[rcc_domain_pkg::dom_d1] = d1_standby;
    assign standby_vec[rcc_domain_pkg::dom_d2] = d2_standby;

    // peripheral held in reset unless enabled and free of its software bit
    function automatic logic [dw-1:0] expected_per_rst(input logic [dw-1:0] rstr,
                                                       input logic [dw-1:0] mask,
                                                       input logic enable);
        logic [dw-1:0] v;
        for (int i = 0; i < dw; i++) begin
            v[i] = enable && !(mask[i] && rstr[i]);
        end
        return v;
    endfunction

    function automatic logic [dw-1:0] expected_read(input rcc_reg_pkg::reg_addr_t addr);
        case (addr)
            rcc_reg_pkg::addr_d1_rstr: return sh_d1;
            rcc_reg_pkg::addr_d2_rstr: return sh_d2;
            rcc_reg_pkg::addr_d3_rstr: return sh_d3;
            default:                   return '0;
        endcase
    endfunction

    function automatic rcc_reg_pkg::reg_addr_t reg_offset(input int idx);
        case (idx)
            0:       return rcc_reg_pkg::addr_d1_rstr;
            1:       return rcc_reg_pkg::addr_d2_rstr;
            default: return rcc_reg_pkg::addr_d3_rstr;
        endcase
    endfunction

    // model, updated with the inputs the DUT samples at the same edge
    always @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            sh_d1 = '0;
            sh_d2 = '0;
            sh_d3 = '0;
            exp_dom = '0;
            for (int i = 0; i < nd; i++) begin
                hold[i] = release_delay + 2;
            end
        end else begin
            if (wr_en) begin
                case (wr_addr)
                    rcc_reg_pkg::addr_d1_rstr: sh_d1 = wr_data & d1_mask;
                    rcc_reg_pkg::addr_d2_rstr: sh_d2 = wr_data & d2_mask;
                    rcc_reg_pkg::addr_d3_rstr: sh_d3 = wr_data & d3_mask;
                    default: ;
                endcase
            end
            for (int i = 0; i < nd; i++) begin
                if (standby_vec[i]) begin
                    exp_dom[i] = 1'b0;
                    hold[i] = release_delay;
                end else if (hold[i] > 0) begin
                    hold[i]--;
                    if (hold[i] == 0) exp_dom[i] = 1'b1;
                end
            end
        end
    end

    task automatic check_per_rst(input string name, input logic [dw-1:0] got,
                                 input logic [dw-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rd(input rcc_reg_pkg::reg_addr_t addr, input logic [dw-1:0] got,
                            input logic [dw-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR rd_data at %h: got %h expected %h", addr, got, exp);
        end
    endtask

    task automatic check_dom_rst(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // outputs are settled half a cycle after the edge
    always @(negedge hclk) begin
        if (check_en) begin
            check_per_rst("d1_per_rst_n", d1_per_rst_n,
                expected_per_rst(sh_d1, d1_mask, rst_n & exp_dom[rcc_domain_pkg::dom_d1]));
            check_per_rst("d2_per_rst_n", d2_per_rst_n,
                expected_per_rst(sh_d2, d2_mask, rst_n & exp_dom[rcc_domain_pkg::dom_d2]));
            check_per_rst("d3_per_rst_n", d3_per_rst_n, expected_per_rst(sh_d3, d3_mask, rst_n));
            check_dom_rst("d1_rst_n", d1_rst_n, exp_dom[rcc_domain_pkg::dom_d1]);
            check_dom_rst("d2_rst_n", d2_rst_n, exp_dom[rcc_domain_pkg::dom_d2]);
            check_rd(rd_addr, rd_data, expected_read(rd_addr));
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge hclk);
    endtask

    task automatic write_reg(input rcc_reg_pkg::reg_addr_t addr, input logic [dw-1:0] data);
        @(posedge hclk);
        wr_en <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        rd_addr <= addr;
        @(posedge hclk);
        wr_en <= 1'b0;
    endtask

    task automatic set_standby(input int dom, input logic v);
        @(posedge hclk);
        if (dom == 0) d1_standby <= v;
        else d2_standby <= v;
    endtask

    // counts edges from the drop of standby or rst_n until the domain opens
    task automatic measure_release(input int dom, input int expected);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < expected + 20) begin
            @(posedge hclk);
            n++;
            @(negedge hclk);
            seen = (dom == 0) ? d1_rst_n : d2_rst_n;
        end
        if (!seen) begin
            step_errors++;
            $display("d%0d_rst_n was never released", dom + 1);
        end else if (n != expected) begin
            step_errors++;
            $display("d%0d_rst_n released after %0d edges instead of %0d", dom + 1, n, expected);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err_start = err_count + step_errors;
    endtask

    task automatic end_test();
        @(posedge hclk);
        tests_run++;
        if (err_count + step_errors == test_err_start) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name,
                     err_count + step_errors - test_err_start);
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns before the tests finished", timeout_ns);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [31:0]            r;
        logic [dw-1:0]          one_hot;
        rcc_reg_pkg::reg_addr_t addr;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_addr = '0;
        d1_standby = 1'b0;
        d2_standby = 1'b0;
        @(posedge hclk);
        check_en = 1'b1;

        begin_test("reset_release");
        idle(9);
        rst_n <= 1'b1;
        measure_release(0, release_delay + 2);
        end_test();

        begin_test("random_write_readback");
        for (int k = 0; k < num_rand; k++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    addr = rcc_reg_pkg::addr_d1_rstr;
                2'd1:    addr = rcc_reg_pkg::addr_d2_rstr;
                2'd2:    addr = rcc_reg_pkg::addr_d3_rstr;
                default: addr = r[7:4];
            endcase
            write_reg(addr, $random(seed));
            @(posedge hclk);
            rd_addr <= r[11:8];
        end
        end_test();

        begin_test("software_reset_per_bit");
        for (int d = 0; d < 3; d++) begin
            for (int b = 0; b < dw; b++) begin
                one_hot = '0;
                one_hot[b] = 1'b1;
                write_reg(reg_offset(d), one_hot);
            end
            write_reg(reg_offset(d), '1);
            write_reg(reg_offset(d), '0);
        end
        end_test();

        begin_test("domain_standby");
        for (int d = 0; d < nd; d++) begin
            set_standby(d, 1'b1);
            idle(3);
            // the other switchable domain keeps working
            write_reg(reg_offset(1 - d), $random(seed));
            set_standby(d, 1'b0);
            measure_release(d, release_delay);
        end
        end_test();

        begin_test("release_restart");
        for (int d = 0; d < nd; d++) begin
            set_standby(d, 1'b1);
            idle(2);
            set_standby(d, 1'b0);
            idle(2);
            set_standby(d, 1'b1);
            set_standby(d, 1'b0);
            measure_release(d, release_delay);
        end
        end_test();

        begin_test("mid_run_system_reset");
        write_reg(rcc_reg_pkg::addr_d1_rstr, '1);
        write_reg(rcc_reg_pkg::addr_d2_rstr, '1);
        write_reg(rcc_reg_pkg::addr_d3_rstr, '1);
        @(posedge hclk);
        rst_n <= 1'b0;
        for (int k = 0; k < 6; k++) begin
            @(posedge hclk);
            rd_addr <= reg_offset(k % 3);
        end
        @(posedge hclk);
        rst_n <= 1'b1;
        measure_release(0, release_delay + 2);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count + step_errors);
        if (err_count + step_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/rcc_reg_pkg.sv
hdl/rcc_domain_pkg.sv
hdl/rcc_rst_regs.sv
hdl/rcc_domain_rst_seq.sv
hdl/rcc_per_rst_combine.sv
hdl/rcc_rst_top.sv
tb/rcc_rst_tb.sv

/* run.sh */
#!/bin/sh
# build and run the reset-control testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module rcc_rst_tb -o rcc_rst_sim \
    && ./obj_dir/rcc_rst_sim | tee sim.log \
    || echo "build or simulation did not complete"
grep -qx "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
